// File: Bender.yml
package:
  name: gauss_blur

sources:
  - include_dirs:
      - include
    files:
      - hw/blur_pkg.sv
      - hw/pixel_in_port.sv
      - hw/window_former.sv
      - hw/gauss_lane.sv
      - hw/pixel_out_port.sv
      - hw/blur_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_blur.sv

// File: filelist.f
+incdir+include
hw/blur_pkg.sv
hw/pixel_in_port.sv
hw/window_former.sv
hw/gauss_lane.sv
hw/pixel_out_port.sv
hw/blur_top.sv
testbench/tb_blur.sv

// File: hw/blur_pkg.sv
`default_nettype none

`include "blur_consts.svh"

package blur_pkg;

    ////////////////////////////////////////
    // plain vectors
    ////////////////////////////////////////

    // red in the top nibble, blue in the bottom one
    typedef logic [`BLUR_NUM_CHAN*`BLUR_CHAN_BITS-1:0] pixel_t;
    typedef logic [`BLUR_CHAN_BITS-1:0] chan_t;
    typedef logic [`BLUR_COL_BITS-1:0] col_t;
    typedef logic [`BLUR_ROW_BITS-1:0] row_t;

    ////////////////////////////////////////
    // structs
    ////////////////////////////////////////

    // beat on the input port
    typedef struct packed {
        logic   sof;
        pixel_t pixel;
    } in_beat_t;

    // accepted pixel tagged with its frame position
    typedef struct packed {
        pixel_t pixel;
        row_t   row;
        col_t   col;
    } pos_pixel_t;

    // 3x3 neighbourhood in raster order, p4 is the centre
    typedef struct packed {
        pixel_t p0, p1, p2;
        pixel_t p3, p4, p5;
        pixel_t p6, p7, p8;
    } window_t;

    // same layout for a single colour channel
    typedef struct packed {
        chan_t p0, p1, p2;
        chan_t p3, p4, p5;
        chan_t p6, p7, p8;
    } chan_window_t;

    // four-phase sequence, shared by both ports
    typedef enum logic [1:0] {
        hs_idle,
        hs_hold,
        hs_release
    } hs_state_t;

endpackage

`default_nettype wire

// File: hw/blur_top.sv
`default_nettype none

`include "blur_consts.svh"

module blur_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_req,
    input  blur_pkg::in_beat_t in_beat,
    output logic               in_ack,
    output logic               out_req,
    input  logic               out_ack,
    output blur_pkg::pixel_t   out_pixel
);
    import blur_pkg::*;

    localparam int CB = `BLUR_CHAN_BITS;

    // input port to window former
    logic       accept;
    pos_pixel_t accept_beat;

    // output queue credit back to the input port
    logic space;

    // window former to lanes
    logic    win_valid;
    window_t window;

    // per-lane slices and results
    chan_window_t             chan_win [`BLUR_NUM_CHAN];
    logic [`BLUR_NUM_CHAN-1:0] lane_valid;
    pixel_t                   results;

    pixel_in_port in_port_i (
        .clk         (clk),
        .reset       (reset),
        .in_req      (in_req),
        .in_beat     (in_beat),
        .space       (space),
        .in_ack      (in_ack),
        .accept      (accept),
        .accept_beat (accept_beat)
    );

    window_former window_i (
        .clk         (clk),
        .reset       (reset),
        .accept      (accept),
        .accept_beat (accept_beat),
        .win_valid   (win_valid),
        .window      (window)
    );

    ////////////////////////////////////////
    // one lane per channel, lane 0 is blue
    ////////////////////////////////////////

    for (genvar ch = 0; ch < `BLUR_NUM_CHAN; ch++) begin : g_lane
        assign chan_win[ch] = '{
            p0: window.p0[ch*CB +: CB], p1: window.p1[ch*CB +: CB], p2: window.p2[ch*CB +: CB],
            p3: window.p3[ch*CB +: CB], p4: window.p4[ch*CB +: CB], p5: window.p5[ch*CB +: CB],
            p6: window.p6[ch*CB +: CB], p7: window.p7[ch*CB +: CB], p8: window.p8[ch*CB +: CB]
        };

        gauss_lane lane_i (
            .clk        (clk),
            .reset      (reset),
            .win_valid  (win_valid),
            .chan_win   (chan_win[ch]),
            .lane_valid (lane_valid[ch]),
            .result     (results[ch*CB +: CB])
        );
    end

    // lanes run in lockstep, lane 0 speaks for all
    pixel_out_port out_port_i (
        .clk        (clk),
        .reset      (reset),
        .accept     (accept),
        .lane_valid (lane_valid[0]),
        .results    (results),
        .out_ack    (out_ack),
        .space      (space),
        .out_req    (out_req),
        .out_pixel  (out_pixel)
    );

endmodule

`default_nettype wire

// File: hw/gauss_lane.sv
`default_nettype none

`include "blur_consts.svh"

module gauss_lane (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   win_valid,
    input  blur_pkg::chan_window_t chan_win,
    output logic                   lane_valid,
    output blur_pkg::chan_t        result
);
    import blur_pkg::*;

    // kernel weights add up to 16, four extra bits hold the full sum
    localparam int SUM_W = `BLUR_CHAN_BITS + 4;

    logic [SUM_W-1:0] corner_sum;
    logic [SUM_W-1:0] edge_sum;
    logic [SUM_W-1:0] centre_tap;
    logic [SUM_W-1:0] total;

    // weight 1
    assign corner_sum = SUM_W'(chan_win.p0) + SUM_W'(chan_win.p2)
                      + SUM_W'(chan_win.p6) + SUM_W'(chan_win.p8);

    // weight 2
    assign edge_sum = SUM_W'(chan_win.p1) + SUM_W'(chan_win.p3)
                    + SUM_W'(chan_win.p5) + SUM_W'(chan_win.p7);

    // weight 4
    assign centre_tap = SUM_W'(chan_win.p4);

    assign total = corner_sum + (edge_sum << 1) + (centre_tap << 2);

    // divide by 16, keep the top nibble
    always_ff @(posedge clk) begin
        if (win_valid) begin
            result <= total[SUM_W-1 -: `BLUR_CHAN_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= win_valid;
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_in_port.sv
`default_nettype none

`include "blur_consts.svh"

module pixel_in_port (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_req,
    input  blur_pkg::in_beat_t   in_beat,
    input  logic                 space,
    output logic                 in_ack,
    output logic                 accept,
    output blur_pkg::pos_pixel_t accept_beat
);
    import blur_pkg::*;

    localparam col_t LAST_COL = col_t'(`BLUR_WIDTH - 1);

    hs_state_t state;

    // position the next beat lands on
    row_t row_cnt;
    col_t col_cnt;

    // position of the beat on the port right now
    row_t beat_row;
    col_t beat_col;

    logic take;

    // sof pins the beat to the frame origin
    assign beat_row = in_beat.sof ? '0 : row_cnt;
    assign beat_col = in_beat.sof ? '0 : col_cnt;

    // only sample when the output side has a free credit
    assign take = (state == hs_idle) && in_req && space;

    ////////////////////////////////////////
    // four-phase receive
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= hs_idle;
            in_ack <= 1'b0;
            accept <= 1'b0;
        end else begin
            // accept is a single-cycle strobe
            accept <= 1'b0;
            case (state)
                hs_idle: begin
                    if (take) begin
                        in_ack <= 1'b1;
                        accept <= 1'b1;
                        state  <= hs_hold;
                    end
                end
                hs_hold: begin
                    // sender has let go of req, drop ack
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        state  <= hs_release;
                    end
                end
                hs_release: begin
                    // one quiet cycle before the next beat
                    state <= hs_idle;
                end
                default: begin
                    state <= hs_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // raster position
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            row_cnt <= '0;
            col_cnt <= '0;
        end else if (take) begin
            if (beat_col == LAST_COL) begin
                // end of row, wrap to the next one
                col_cnt <= '0;
                row_cnt <= beat_row + 1'b1;
            end else begin
                col_cnt <= beat_col + 1'b1;
                row_cnt <= beat_row;
            end
        end
    end

    // beat with its position, held until the next take
    always_ff @(posedge clk) begin
        if (take) begin
            accept_beat.pixel <= in_beat.pixel;
            accept_beat.row   <= beat_row;
            accept_beat.col   <= beat_col;
        end
    end

endmodule

`default_nettype wire

// File: hw/pixel_out_port.sv
`default_nettype none

`include "blur_consts.svh"

module pixel_out_port (
    input  logic             clk,
    input  logic             reset,
    input  logic             accept,
    input  logic             lane_valid,
    input  blur_pkg::pixel_t results,
    input  logic             out_ack,
    output logic             space,
    output logic             out_req,
    output blur_pkg::pixel_t out_pixel
);
    import blur_pkg::*;

    localparam int DEPTH = `BLUR_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    ////////////////////////////////////////
    // queue state
    ////////////////////////////////////////

    pixel_t queue_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // entries written, not yet popped
    logic [CNT_W-1:0] fill;
    // entries reserved at accept, includes pixels still in the pipe
    logic [CNT_W-1:0] credits;

    hs_state_t state;

    logic push;
    logic pop;
    logic launch;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push   = lane_valid;
    // receiver took the pixel
    assign pop    = (state == hs_hold) && out_ack;
    // start a new send when idle and something is waiting
    assign launch = (state == hs_idle) && (fill != '0);

    // input side may take another pixel
    assign space = (credits < CNT_W'(DEPTH));

    ////////////////////////////////////////
    // circular queue
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= results;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // reserve at accept, give back at pop
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= '0;
        end else begin
            case ({accept, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    ////////////////////////////////////////
    // four-phase send
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= hs_idle;
            out_req <= 1'b0;
        end else begin
            case (state)
                hs_idle: begin
                    if (launch) begin
                        out_req <= 1'b1;
                        state   <= hs_hold;
                    end
                end
                hs_hold: begin
                    // pop and drop req together
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= hs_release;
                    end
                end
                hs_release: begin
                    // wait for the receiver to finish its half
                    if (!out_ack) begin
                        state <= hs_idle;
                    end
                end
                default: begin
                    state <= hs_idle;
                end
            endcase
        end
    end

    // data held steady for the whole req/ack cycle
    always_ff @(posedge clk) begin
        if (launch) begin
            out_pixel <= queue_mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: hw/window_former.sv
`default_nettype none

`include "blur_consts.svh"

module window_former (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 accept,
    input  blur_pkg::pos_pixel_t accept_beat,
    output logic                 win_valid,
    output blur_pkg::window_t    window
);
    import blur_pkg::*;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    // row r-1 and row r-2, one entry per column
    pixel_t line_prev [`BLUR_WIDTH];
    pixel_t line_old  [`BLUR_WIDTH];

    // column c as it arrives
    // index 0 top (r-2), 1 middle (r-1), 2 bottom (r)
    pixel_t col_now [3];

    // earlier columns per row
    // [i][0] is column c-1, [i][1] is column c-2
    pixel_t hist [3][2];

    // column 0 starts a new run of history
    logic fresh;

    // border masks for the centre at (r-1, c-1)
    logic mask_all;
    logic mask_top;
    logic mask_left;

    window_t raw_win;
    window_t masked_win;

    // read both memories at the incoming column
    assign col_now[0] = line_old[accept_beat.col];
    assign col_now[1] = line_prev[accept_beat.col];
    assign col_now[2] = accept_beat.pixel;

    assign fresh = (accept_beat.col == '0);

    // row 0 or column 0 has no valid centre at all
    assign mask_all  = (accept_beat.row == '0) || (accept_beat.col == '0);
    // centre on row 0, nothing above it
    assign mask_top  = (accept_beat.row == row_t'(1));
    // centre on column 0, nothing left of it
    assign mask_left = (accept_beat.col == col_t'(1));

    ////////////////////////////////////////
    // window assembly
    ////////////////////////////////////////

    always_comb begin
        raw_win = '{
            p0: hist[0][1], p1: hist[0][0], p2: col_now[0],
            p3: hist[1][1], p4: hist[1][0], p5: col_now[1],
            p6: hist[2][1], p7: hist[2][0], p8: col_now[2]
        };
    end

    // out-of-image neighbours count as zero
    always_comb begin
        masked_win = raw_win;
        if (mask_top) begin
            masked_win.p0 = '0;
            masked_win.p1 = '0;
            masked_win.p2 = '0;
        end
        if (mask_left) begin
            masked_win.p0 = '0;
            masked_win.p3 = '0;
            masked_win.p6 = '0;
        end
        // stale memory on row 0 is hidden here too
        if (mask_all) begin
            masked_win = '0;
        end
    end

    ////////////////////////////////////////
    // update on accept
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            // r-1 moves down to r-2, new pixel becomes r-1
            line_old[accept_beat.col]  <= col_now[1];
            line_prev[accept_beat.col] <= col_now[2];

            // shift columns, drop the previous row's tail at column 0
            for (int i = 0; i < 3; i++) begin
                hist[i][0] <= col_now[i];
                hist[i][1] <= fresh ? '0 : hist[i][0];
            end

            window <= masked_win;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= accept;
        end
    end

endmodule

`default_nettype wire

// File: include/blur_consts.svh
`ifndef BLUR_CONSTS_SVH
`define BLUR_CONSTS_SVH

////////////////////////////////////////
// image geometry
////////////////////////////////////////

// columns per row, also the line memory depth
`define BLUR_WIDTH 160

// position counters
`define BLUR_COL_BITS 8
`define BLUR_ROW_BITS 8

////////////////////////////////////////
// pixel format and output side
////////////////////////////////////////

// rgb444, three channels of four bits
`define BLUR_CHAN_BITS 4
`define BLUR_NUM_CHAN 3

// output queue entries
`define BLUR_QUEUE_DEPTH 4

`endif

// File: testbench/tb_blur.sv
`default_nettype none

`include "blur_consts.svh"

module tb_blur;
    import blur_pkg::*;

    localparam int W = `BLUR_WIDTH;
    localparam int MAX_ROWS = 8;
    // beats over all six tests
    localparam int TOTAL_BEATS = 3*W + 3*W + 4*W + (W + 20) + (W + 40) + (W + 30);
    localparam int LIMIT_CYCLES = TOTAL_BEATS * 40 + 4000;

    logic     clk;
    logic     reset;
    logic     in_req;
    in_beat_t in_beat;
    logic     in_ack;
    logic     out_req;
    logic     out_ack;
    pixel_t   out_pixel;

    // software model of the frame seen so far
    pixel_t frame [MAX_ROWS][W];
    int     model_row;
    int     model_col;

    pixel_t exp_q [$];
    pixel_t got_q [$];

    int     ack_delay;
    integer seed;
    string  test_name;
    int     error_count;
    int     check_count;
    int     test_count;
    int     test_err_start;

    blur_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .in_req    (in_req),
        .in_beat   (in_beat),
        .in_ack    (in_ack),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_pixel (out_pixel)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // watchdog and output collector
    ////////////////////////////////////////

    initial begin
        #(LIMIT_CYCLES * 10);
        $display("timeout: test %s still running after %0d cycles", test_name, LIMIT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // receiver side, ack after a per-test delay
    initial begin
        forever begin
            @(negedge clk);
            if (out_req && !out_ack) begin
                repeat (ack_delay) @(negedge clk);
                got_q.push_back(out_pixel);
                out_ack = 1'b1;
                @(negedge clk);
                while (out_req) @(negedge clk);
                out_ack = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // 1-2-1 by 1-2-1 kernel, zero outside the image, divide by 16
    function automatic pixel_t blur_at(input int cr, input int cc);
        pixel_t res;
        int     sum;
        int     rr;
        int     cx;
        int     wt;
        res = '0;
        for (int ch = 0; ch < `BLUR_NUM_CHAN; ch++) begin
            sum = 0;
            for (int dr = -1; dr <= 1; dr++) begin
                for (int dc = -1; dc <= 1; dc++) begin
                    rr = cr + dr;
                    cx = cc + dc;
                    wt = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);
                    if (rr >= 0 && cx >= 0 && cx < W) begin
                        sum += wt * ((frame[rr][cx] >> (4 * ch)) & 15);
                    end
                end
            end
            res[4*ch +: 4] = 4'(sum / 16);
        end
        return res;
    endfunction

    // place one pixel, predict the output it releases
    task automatic model_beat(input logic sof, input pixel_t px);
        int r;
        int c;
        r = sof ? 0 : model_row;
        c = sof ? 0 : model_col;
        frame[r][c] = px;
        if (r == 0 || c == 0) begin
            exp_q.push_back('0);
        end else begin
            exp_q.push_back(blur_at(r - 1, c - 1));
        end
        if (c == W - 1) begin
            model_row = r + 1;
            model_col = 0;
        end else begin
            model_row = r;
            model_col = c + 1;
        end
    endtask

    ////////////////////////////////////////
    // driving and checking
    ////////////////////////////////////////

    // four-phase send, entered and left on a falling edge
    task automatic send_beat(input logic sof, input pixel_t px);
        model_beat(sof, px);
        in_beat.sof   = sof;
        in_beat.pixel = px;
        in_req        = 1'b1;
        @(negedge clk);
        while (!in_ack) @(negedge clk);
        in_req = 1'b0;
        @(negedge clk);
        while (in_ack) @(negedge clk);
    endtask

    task automatic send_random(input int n, input logic sof_first);
        for (int i = 0; i < n; i++) begin
            send_beat(sof_first && i == 0, pixel_t'($random(seed)));
        end
    endtask

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error %s: expected %0h, actual %0h", test_name, expected, actual);
        end
    endtask

    // output at a stream index, x if it never came
    function automatic logic [31:0] out_at(input int idx);
        return (idx < got_q.size()) ? 32'(got_q[idx]) : 'x;
    endfunction

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = error_count;
        exp_q.delete();
        got_q.delete();
    endtask

    // wait for every predicted output, then look for extras
    task automatic drain_and_compare();
        while (got_q.size() < exp_q.size()) @(negedge clk);
        repeat (20) @(negedge clk);
        check_value(exp_q.size(), got_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            check_value(exp_q[i], out_at(i));
        end
    endtask

    task automatic end_test();
        test_count++;
        $display("test %s done, %0d errors", test_name, error_count - test_err_start);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_reset_idle();
        begin_test("reset_idle");
        check_value(0, in_ack);
        check_value(0, out_req);
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value(0, out_req);
        end
        check_value(0, got_q.size());
        end_test();
    endtask

    task automatic test_flat_frame();
        begin_test("flat_frame");
        for (int i = 0; i < 3 * W; i++) begin
            send_beat(i == 0, 12'h888);
        end
        drain_and_compare();
        // row 0, top-left corner, top edge, left edge, interior
        check_value(12'h000, out_at(5));
        check_value(12'h444, out_at(W + 1));
        check_value(12'h666, out_at(W + 40));
        check_value(12'h666, out_at(2*W + 1));
        check_value(12'h888, out_at(2*W + 100));
        end_test();
    endtask

    task automatic test_impulse();
        begin_test("impulse");
        for (int i = 0; i < 3 * W; i++) begin
            send_beat(i == 0, (i == W + 80) ? 12'hfff : 12'h000);
        end
        drain_and_compare();
        // centre, edge below, edge right, edge left, corner
        check_value(12'h333, out_at(2*W + 81));
        check_value(12'h111, out_at(W + 81));
        check_value(12'h111, out_at(2*W + 80));
        check_value(12'h111, out_at(2*W + 82));
        check_value(12'h000, out_at(W + 80));
        end_test();
    endtask

    task automatic test_random_frame();
        begin_test("random_frame");
        send_random(4 * W, 1'b1);
        drain_and_compare();
        end_test();
    endtask

    // slow receiver uses up the credits and stalls the input side
    task automatic test_back_pressure();
        begin_test("back_pressure");
        send_random(W, 1'b1);
        ack_delay = 30;
        send_random(20, 1'b0);
        drain_and_compare();
        ack_delay = 0;
        end_test();
    endtask

    task automatic test_mid_frame_sof();
        begin_test("mid_frame_sof");
        send_random(W + 40, 1'b1);
        send_random(W + 30, 1'b1);
        drain_and_compare();
        end_test();
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        in_req      = 1'b0;
        in_beat     = '0;
        out_ack     = 1'b0;
        ack_delay   = 0;
        seed        = 32'hcb67;
        model_row   = 0;
        model_col   = 0;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        test_name   = "reset";
        repeat (2) @(negedge clk);
        reset = 1'b0;

        test_reset_idle();
        test_flat_frame();
        test_impulse();
        test_random_frame();
        test_back_pressure();
        test_mid_frame_sof();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
